// ==== compile.f ====
source/bomber_pkg.sv
source/powerup_config.sv
source/spawn_rng.sv
source/item_dispatch.sv
source/item_slot.sv
source/player_stats.sv
source/powerup_top.sv
dv/powerup_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the power-up testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module powerup_tb -Mdir obj_dir -o powerup_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/powerup_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit $status
fi

exit 0

// ==== dv/powerup_tb.sv ====
`timescale 1ns/1ps

module powerup_tb;

    localparam int          WAIT_LIMIT = 20;            // Cycles before any wait gives up
    localparam logic [31:0] LFSR_TAPS  = 32'h80200003;  // x^32+x^22+x^2+x+1

    logic                             clk;
    logic                             rst_n;
    logic                             tick;
    logic                             game_over;
    logic                             map_we;
    bomber_pkg::tile_addr_t           map_addr;
    logic [bomber_pkg::TILE_W-1:0]    map_data;
    bomber_pkg::player_pos_t          player;
    logic                             cfg_we;
    bomber_pkg::cfg_sel_e             cfg_sel;
    bomber_pkg::cfg_word_u            cfg_wdata;
    bomber_pkg::slot_state_t          slots [bomber_pkg::NUM_SLOTS];
    logic [bomber_pkg::NUM_SLOTS-1:0] on_item;
    bomber_pkg::stats_t               stats;

    // --------------------
    // Expected state
    // --------------------
    logic [31:0] lfsr_state;
    logic        exp_active [3];
    logic [7:0]  exp_addr [3];
    int          exp_life [3];    // Ticks left per slot
    int          exp_ptr;         // Next slot a freed tile targets
    logic        exp_spawn;       // Set once threshold reaches 65536
    int          exp_lifetime;
    int          exp_speed;
    int          exp_bombs;
    int          exp_range;
    int          exp_speed_cap;
    int          exp_bomb_cap;
    int          exp_range_cap;

    powerup_top i_powerup_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .tick      (tick),
        .game_over (game_over),
        .map_we    (map_we),
        .map_addr  (map_addr),
        .map_data  (map_data),
        .player    (player),
        .cfg_we    (cfg_we),
        .cfg_sel   (cfg_sel),
        .cfg_wdata (cfg_wdata),
        .slots     (slots),
        .on_item   (on_item),
        .stats     (stats)
    );

    always #50 clk = ~clk;  // 100 ns period

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else
            abort_run($sformatf("ERROR %s = 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ LFSR_TAPS;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic bomber_pkg::cfg_word_u limit_word(input logic [7:0] life,
            input logic [5:0] speed_cap, input logic [3:0] bomb_cap, input logic [3:0] range_cap);
        bomber_pkg::cfg_word_u w;
        w = '0;
        w.limit_view.lifetime  = life;
        w.limit_view.speed_cap = speed_cap;
        w.limit_view.bomb_cap  = bomb_cap;
        w.limit_view.range_cap = range_cap;
        return w;
    endfunction

    // Random tile other than tile 0 (player parks there) or a live item tile
    task automatic fresh_tile(output logic [7:0] t);
        int   tries;
        logic ok;
        tries = 0;
        ok    = 1'b0;
        while (!ok) begin
            assert (tries < 1000) else abort_run("no unused tile address could be drawn");
            t  = 8'(next_bits(8));
            ok = (t != 8'd0) && (t < bomber_pkg::MAP_DEPTH);
            for (int i = 0; i < 3; i++) begin
                if (exp_active[i] && (exp_addr[i] == t)) ok = 1'b0;
            end
            tries++;
        end
    endtask

    task automatic compare_all();
        for (int i = 0; i < 3; i++) begin
            check_eq($sformatf("slots[%0d].active", i), 32'(slots[i].active), 32'(exp_active[i]));
            if (exp_active[i]) begin
                check_eq($sformatf("slots[%0d].addr", i), 32'(slots[i].addr), 32'(exp_addr[i]));
            end
        end
        check_eq("on_item", 32'(on_item), 32'd0);
        check_eq("stats.speed", 32'(stats.speed), exp_speed);
        check_eq("stats.max_bombs", 32'(stats.max_bombs), exp_bombs);
        check_eq("stats.bomb_range", 32'(stats.bomb_range), exp_range);
    endtask

    task automatic wait_active(input int idx);
        int n;
        n = 0;
        while (slots[idx].active !== 1'b1) begin
            assert (n < WAIT_LIMIT) else
                abort_run($sformatf("slot %0d never became active after a spawn", idx));
            @(negedge clk);
            n++;
        end
    endtask

    // --------------------
    // Stimulus tasks
    // --------------------
    // All of them start and end on a falling edge

    task automatic write_cfg(input bomber_pkg::cfg_sel_e sel, input bomber_pkg::cfg_word_u word);
        cfg_we    = 1'b1;
        cfg_sel   = sel;
        cfg_wdata = word;
        @(negedge clk);
        cfg_we = 1'b0;
        case (sel)
            bomber_pkg::PROB:   exp_spawn = (word.prob_view.threshold >= 17'h10000);
            bomber_pkg::TIMING: exp_lifetime = word.limit_view.lifetime;
            default: begin
                exp_speed_cap = word.limit_view.speed_cap;
                exp_bomb_cap  = word.limit_view.bomb_cap;
                exp_range_cap = word.limit_view.range_cap;
            end
        endcase
    endtask

    task automatic free_tile(input logic [7:0] addr, input logic [1:0] data);
        int   target;
        logic spawn_here;
        target     = exp_ptr;
        spawn_here = (data == bomber_pkg::TILE_EMPTY) && exp_spawn && !exp_active[target];
        map_we     = 1'b1;
        map_addr   = addr;
        map_data   = data;
        @(negedge clk);
        map_we = 1'b0;
        if (data == bomber_pkg::TILE_EMPTY) exp_ptr = (exp_ptr + 1) % 3;  // Spawn or not
        if (spawn_here) begin
            exp_active[target] = 1'b1;
            exp_addr[target]   = addr;
            exp_life[target]   = exp_lifetime;
            wait_active(target);
        end else begin
            repeat (2) @(negedge clk);  // Nothing should show up
        end
        compare_all();
    endtask

    task automatic pulse_tick();
        tick = 1'b1;
        @(negedge clk);
        tick = 1'b0;
        for (int i = 0; i < 3; i++) begin
            if (exp_active[i]) begin
                if (exp_life[i] <= 1) exp_active[i] = 1'b0;  // Expired
                else exp_life[i]--;
            end
        end
        compare_all();
    endtask

    // Free tiles until the rotation lands an item in slot idx
    task automatic place_item(input int idx);
        logic [7:0] t;
        int         tries;
        tries = 0;
        while (!exp_active[idx]) begin
            assert (tries < 3) else abort_run("slot rotation never reached the wanted slot");
            fresh_tile(t);
            free_tile(t, bomber_pkg::TILE_EMPTY);
            tries++;
        end
    endtask

    // Walk onto the item tile centre and back, expecting one pulse
    task automatic collect(input int idx);
        int n;
        int row;
        int col;
        row      = exp_addr[idx] / bomber_pkg::NUM_COL;
        col      = exp_addr[idx] % bomber_pkg::NUM_COL;
        player.x = 11'((col << bomber_pkg::TILE_SHIFT) + 32);
        player.y = 10'((row << bomber_pkg::TILE_SHIFT) + 32);
        n = 0;
        do begin
            @(negedge clk);
            n++;
            assert (n <= WAIT_LIMIT) else abort_run("no pickup pulse while standing on an item");
        end while (on_item == '0);
        check_eq("on_item", 32'(on_item), 32'(1 << idx));
        player.x = 11'd32;  // Back to tile 0
        player.y = 10'd32;
        exp_active[idx] = 1'b0;
        if (idx == 0 && exp_speed + 4 <= exp_speed_cap) exp_speed += 4;
        if (idx == 1 && exp_bombs + 1 <= exp_bomb_cap) exp_bombs++;
        if (idx == 2 && exp_range + 1 <= exp_range_cap) exp_range++;
        @(negedge clk);
        compare_all();  // Pulse gone and stats updated
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic idle_after_reset();
        logic [7:0] t;
        compare_all();  // Init stats and empty slots
        repeat (6) begin  // Multiple of 3 leaves rotation at slot 0
            fresh_tile(t);
            free_tile(t, bomber_pkg::TILE_EMPTY);
        end
    endtask

    task automatic fill_slots_in_order();
        bomber_pkg::cfg_word_u w;
        logic [7:0]            t;
        w = '0;
        w.prob_view.threshold = 17'h10000;  // Always spawn
        write_cfg(bomber_pkg::PROB, w);
        for (int i = 0; i < 3; i++) begin
            fresh_tile(t);
            free_tile(t, bomber_pkg::TILE_EMPTY);
            check_eq($sformatf("slots[%0d].addr", i), 32'(slots[i].addr), 32'(t));
        end
        fresh_tile(t);
        free_tile(t, 2'd1);  // Not a freed tile
        fresh_tile(t);
        free_tile(t, bomber_pkg::TILE_EMPTY);  // Slot 0 busy so the item is lost
    endtask

    task automatic pickups_up_to_caps();
        collect(1);
        write_cfg(bomber_pkg::CAPS, limit_word(8'd1, 6'd12, 4'd3, 4'd9));  // Lifetime ignored
        repeat (3) begin
            place_item(1);
            collect(1);
        end
        check_eq("stats.max_bombs", 32'(stats.max_bombs), 32'd3);
        repeat (4) begin
            place_item(0);
            collect(0);
        end
        check_eq("stats.speed", 32'(stats.speed), 32'd12);
        place_item(2);
        collect(2);
    endtask

    task automatic expire_item();
        write_cfg(bomber_pkg::TIMING, limit_word(8'd3, 6'd0, 4'd0, 4'd0));  // Caps ignored
        place_item(2);
        pulse_tick();
        pulse_tick();
        check_eq("slots[2].active", 32'(slots[2].active), 32'd1);
        pulse_tick();
        check_eq("slots[2].active", 32'(slots[2].active), 32'd0);
    endtask

    task automatic clear_on_game_over();
        logic [7:0] t;
        place_item(0);
        place_item(1);
        game_over = 1'b1;
        @(negedge clk);
        game_over = 1'b0;
        for (int i = 0; i < 3; i++) exp_active[i] = 1'b0;
        exp_ptr   = 0;
        exp_speed = 4;
        exp_bombs = 1;
        exp_range = 1;
        compare_all();
        fresh_tile(t);
        free_tile(t, bomber_pkg::TILE_EMPTY);  // Threshold survived
        repeat (3) pulse_tick();               // Lifetime 3 survived
        repeat (3) begin
            place_item(0);
            collect(0);
        end
        check_eq("stats.speed", 32'(stats.speed), 32'd12);  // Speed cap survived
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        tick       = 1'b0;
        game_over  = 1'b0;
        map_we     = 1'b0;
        map_addr   = '0;
        map_data   = 2'd1;
        player.x   = 11'd32;  // Centre of tile 0
        player.y   = 10'd32;
        cfg_we     = 1'b0;
        cfg_sel    = bomber_pkg::PROB;
        cfg_wdata  = '0;
        lfsr_state = 32'd92463;
        for (int i = 0; i < 3; i++) begin
            exp_active[i] = 1'b0;
            exp_addr[i]   = '0;
            exp_life[i]   = 0;
        end
        exp_ptr       = 0;
        exp_spawn     = 1'b0;
        exp_lifetime  = 6;
        exp_speed     = 4;
        exp_bombs     = 1;
        exp_range     = 1;
        exp_speed_cap = 28;
        exp_bomb_cap  = 9;
        exp_range_cap = 9;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        idle_after_reset();
        fill_slots_in_order();
        pickups_up_to_caps();
        expire_item();
        clear_on_game_over();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== source/powerup_top.sv ====
`timescale 1ns/1ps

module powerup_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             tick,
    input  logic                             game_over,
    input  logic                             map_we,
    input  bomber_pkg::tile_addr_t           map_addr,
    input  logic [bomber_pkg::TILE_W-1:0]    map_data,
    input  bomber_pkg::player_pos_t          player,
    input  logic                             cfg_we,
    input  bomber_pkg::cfg_sel_e             cfg_sel,
    input  bomber_pkg::cfg_word_u            cfg_wdata,
    output bomber_pkg::slot_state_t          slots [bomber_pkg::NUM_SLOTS],
    output logic [bomber_pkg::NUM_SLOTS-1:0] on_item,
    output bomber_pkg::stats_t               stats
);

    bomber_pkg::cfg_t                 cfg;          // Live settings
    logic [15:0]                      rng_value;
    logic [bomber_pkg::NUM_SLOTS-1:0] spawn_we;     // One-hot per slot
    bomber_pkg::tile_addr_t           spawn_addr;
    bomber_pkg::tile_addr_t           player_tile;  // Registered once

    // --------------------
    // Control path
    // --------------------
    powerup_config i_powerup_config (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_sel   (cfg_sel),
        .cfg_wdata (cfg_wdata),
        .cfg       (cfg)
    );

    spawn_rng i_spawn_rng (
        .clk       (clk),
        .rst_n     (rst_n),
        .rng_value (rng_value)
    );

    item_dispatch i_item_dispatch (
        .clk         (clk),
        .rst_n       (rst_n),
        .game_over   (game_over),
        .map_we      (map_we),
        .map_addr    (map_addr),
        .map_data    (map_data),
        .player      (player),
        .threshold   (cfg.threshold),
        .rng_value   (rng_value),
        .spawn_we    (spawn_we),
        .spawn_addr  (spawn_addr),
        .player_tile (player_tile)
    );

    // --------------------
    // Item slots
    // --------------------
    // Index 0 speed, 1 extra bomb, 2 range
    for (genvar i = 0; i < bomber_pkg::NUM_SLOTS; i++) begin : g_slot
        item_slot i_item_slot (
            .clk         (clk),
            .rst_n       (rst_n),
            .tick        (tick),
            .game_over   (game_over),
            .spawn_we    (spawn_we[i]),
            .spawn_addr  (spawn_addr),
            .player_tile (player_tile),
            .lifetime    (cfg.lifetime),
            .slot        (slots[i]),
            .picked      (on_item[i])
        );
    end

    player_stats i_player_stats (
        .clk       (clk),
        .rst_n     (rst_n),
        .game_over (game_over),
        .picked    (on_item),
        .cfg       (cfg),
        .stats     (stats)
    );

endmodule

// ==== source/player_stats.sv ====
`timescale 1ns/1ps

module player_stats (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            game_over,
    input  logic [bomber_pkg::NUM_SLOTS-1:0] picked,
    input  bomber_pkg::cfg_t                cfg,
    output bomber_pkg::stats_t              stats
);

    // One extra bit so the cap check never wraps
    logic [6:0] speed_sum;
    logic [4:0] bomb_sum;
    logic [4:0] range_sum;

    assign speed_sum = {1'b0, stats.speed} + {1'b0, bomber_pkg::SPEED_STEP};
    assign bomb_sum  = {1'b0, stats.max_bombs} + 5'd1;
    assign range_sum = {1'b0, stats.bomb_range} + 5'd1;

    // --------------------
    // Capped counters
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stats.speed      <= bomber_pkg::SPEED_INIT;
            stats.max_bombs  <= bomber_pkg::BOMBS_INIT;
            stats.bomb_range <= bomber_pkg::RANGE_INIT;
        end else if (game_over) begin
            // Back to starting loadout
            stats.speed      <= bomber_pkg::SPEED_INIT;
            stats.max_bombs  <= bomber_pkg::BOMBS_INIT;
            stats.bomb_range <= bomber_pkg::RANGE_INIT;
        end else begin
            // Slot 0 is speed
            if (picked[0] && (speed_sum <= {1'b0, cfg.speed_cap})) begin
                stats.speed <= speed_sum[5:0];
            end
            // Slot 1 is extra bomb
            if (picked[1] && (bomb_sum <= {1'b0, cfg.bomb_cap})) begin
                stats.max_bombs <= bomb_sum[3:0];
            end
            // Slot 2 is blast range
            if (picked[2] && (range_sum <= {1'b0, cfg.range_cap})) begin
                stats.bomb_range <= range_sum[3:0];
            end
        end
    end

endmodule

// ==== source/item_slot.sv ====
`timescale 1ns/1ps

module item_slot (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    tick,
    input  logic                    game_over,
    input  logic                    spawn_we,
    input  bomber_pkg::tile_addr_t  spawn_addr,
    input  bomber_pkg::tile_addr_t  player_tile,
    input  logic [7:0]              lifetime,
    output bomber_pkg::slot_state_t slot,
    output logic                    picked
);

    bomber_pkg::tile_addr_t addr_q;
    logic                   active_q;
    logic [7:0]             life_cnt;  // Ticks left
    logic                   load;
    logic                   on_tile;

    // Occupied slot drops the spawn
    assign load    = spawn_we && !active_q && !game_over;
    assign on_tile = active_q && (addr_q == player_tile);

    // --------------------
    // Slot state
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_q <= 1'b0;
            life_cnt <= '0;
            picked   <= 1'b0;
        end else begin
            picked <= 1'b0;  // Single cycle pulse
            if (game_over) begin
                active_q <= 1'b0;
            end else if (on_tile) begin
                // Player collects, item gone
                picked   <= 1'b1;
                active_q <= 1'b0;
            end else if (active_q && tick) begin
                if (life_cnt <= 8'd1) begin
                    active_q <= 1'b0;  // Expired, no pickup
                end else begin
                    life_cnt <= life_cnt - 8'd1;
                end
            end else if (load) begin
                active_q <= 1'b1;
                life_cnt <= lifetime;  // Fresh lifetime per spawn
            end
        end
    end

    // Tile address, only meaningful while active
    always_ff @(posedge clk) begin
        if (load) begin
            addr_q <= spawn_addr;
        end
    end

    assign slot.addr   = addr_q;
    assign slot.active = active_q;

endmodule

// ==== source/item_dispatch.sv ====
`timescale 1ns/1ps

module item_dispatch (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  game_over,
    input  logic                                  map_we,
    input  bomber_pkg::tile_addr_t                map_addr,
    input  logic [bomber_pkg::TILE_W-1:0]         map_data,
    input  bomber_pkg::player_pos_t               player,
    input  logic [16:0]                           threshold,
    input  logic [15:0]                           rng_value,
    output logic [bomber_pkg::NUM_SLOTS-1:0]      spawn_we,
    output bomber_pkg::tile_addr_t                spawn_addr,
    output bomber_pkg::tile_addr_t                player_tile
);

    localparam int PTR_W = $clog2(bomber_pkg::NUM_SLOTS);

    logic             freed;     // Map write of an empty tile
    logic             rng_hit;   // Random draw under threshold
    logic [PTR_W-1:0] slot_ptr;  // Next slot type to target

    logic [9-bomber_pkg::TILE_SHIFT:0]  tile_row;
    logic [10-bomber_pkg::TILE_SHIFT:0] tile_col;

    assign freed   = map_we && (map_data == bomber_pkg::TILE_EMPTY);
    assign rng_hit = {1'b0, rng_value} < threshold;  // 17 bit so 65536 always wins

    // --------------------
    // Slot rotation
    // --------------------
    // Rotates on every freed tile, spawn or not
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_ptr <= '0;
        end else if (game_over) begin
            slot_ptr <= '0;
        end else if (freed) begin
            if (slot_ptr == PTR_W'(bomber_pkg::NUM_SLOTS - 1)) begin
                slot_ptr <= '0;  // Wrap back to speed slot
            end else begin
                slot_ptr <= slot_ptr + 1'b1;
            end
        end
    end

    // --------------------
    // Spawn strobe
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            spawn_we <= '0;
        end else if (game_over) begin
            spawn_we <= '0;  // Nothing lands after game over
        end else if (freed && rng_hit) begin
            spawn_we <= bomber_pkg::NUM_SLOTS'(1) << slot_ptr;  // One-hot target
        end else begin
            spawn_we <= '0;
        end
    end

    // Address rides along with the strobe
    always_ff @(posedge clk) begin
        if (freed) begin
            spawn_addr <= map_addr;
        end
    end

    // --------------------
    // Player tile
    // --------------------
    assign tile_row = player.y[9:bomber_pkg::TILE_SHIFT];   // Pixel to row
    assign tile_col = player.x[10:bomber_pkg::TILE_SHIFT];  // Pixel to column

    // Row major index, shared by all slots
    always_ff @(posedge clk) begin
        player_tile <= bomber_pkg::tile_addr_t'(tile_row * bomber_pkg::NUM_COL + tile_col);
    end

endmodule

// ==== source/spawn_rng.sv ====
`timescale 1ns/1ps

module spawn_rng (
    input  logic        clk,
    input  logic        rst_n,
    output logic [15:0] rng_value
);

    // --------------------
    // Galois LFSR
    // --------------------
    logic [15:0] lfsr;
    logic [15:0] lfsr_next;

    // Shift right, fold taps back in when a one falls out
    assign lfsr_next = {1'b0, lfsr[15:1]} ^ (lfsr[0] ? bomber_pkg::RNG_TAPS : 16'h0000);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr <= bomber_pkg::RNG_SEED;  // Non-zero, never locks up
        end else begin
            lfsr <= lfsr_next;  // Step every cycle
        end
    end

    assign rng_value = lfsr;  // Full state as sample

endmodule

// ==== source/powerup_config.sv ====
`timescale 1ns/1ps

module powerup_config (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cfg_we,
    input  bomber_pkg::cfg_sel_e  cfg_sel,
    input  bomber_pkg::cfg_word_u cfg_wdata,
    output bomber_pkg::cfg_t      cfg
);

    // --------------------
    // Register file
    // --------------------
    // Three logical registers, each write lands at the next edge

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg.threshold <= bomber_pkg::RESET_THRESHOLD;  // Spawning off
            cfg.lifetime  <= bomber_pkg::RESET_LIFETIME;
            cfg.speed_cap <= bomber_pkg::RESET_SPEED_CAP;
            cfg.bomb_cap  <= bomber_pkg::RESET_BOMB_CAP;
            cfg.range_cap <= bomber_pkg::RESET_RANGE_CAP;
        end else if (cfg_we) begin
            case (cfg_sel)
                bomber_pkg::PROB: begin
                    // Threshold compared against 16 bit RNG
                    cfg.threshold <= cfg_wdata.prob_view.threshold;
                end
                bomber_pkg::TIMING: begin
                    // Only the lifetime field counts here
                    cfg.lifetime <= cfg_wdata.limit_view.lifetime;
                end
                bomber_pkg::CAPS: begin
                    // Same layout, cap fields only
                    cfg.speed_cap <= cfg_wdata.limit_view.speed_cap;
                    cfg.bomb_cap  <= cfg_wdata.limit_view.bomb_cap;
                    cfg.range_cap <= cfg_wdata.limit_view.range_cap;
                end
                default: begin
                    // Unmapped select, write dropped
                end
            endcase
        end
    end

endmodule

// ==== source/bomber_pkg.sv ====
package bomber_pkg;

    // --------------------
    // Map geometry
    // --------------------
    localparam int NUM_ROW    = 11;
    localparam int NUM_COL    = 19;
    localparam int MAP_DEPTH  = NUM_ROW * NUM_COL;  // 209 tiles
    localparam int ADDR_W     = $clog2(MAP_DEPTH);  // 8 bit tile index
    localparam int TILE_SHIFT = 6;                  // 64 px per tile
    localparam int TILE_W     = 2;                  // Map memory word

    localparam logic [TILE_W-1:0] TILE_EMPTY = 2'd0;  // Tile just freed

    localparam int NUM_SLOTS = 3;  // Speed, bomb, range

    typedef logic [ADDR_W-1:0] tile_addr_t;

    // --------------------
    // Configuration
    // --------------------
    typedef enum logic [1:0] {
        PROB   = 2'd0,
        TIMING = 2'd1,
        CAPS   = 2'd2
    } cfg_sel_e;

    // Spawn probability write
    typedef struct packed {
        logic [14:0] pad;
        logic [16:0] threshold;  // 65536 means always
    } prob_view_t;

    // Lifetime and cap writes share this layout
    typedef struct packed {
        logic [9:0] pad;
        logic [3:0] range_cap;
        logic [3:0] bomb_cap;
        logic [5:0] speed_cap;
        logic [7:0] lifetime;  // In game ticks
    } limit_view_t;

    typedef union packed {
        prob_view_t  prob_view;
        limit_view_t limit_view;
    } cfg_word_u;

    // Live settings seen by the rest of the subsystem
    typedef struct packed {
        logic [16:0] threshold;
        logic [7:0]  lifetime;
        logic [5:0]  speed_cap;
        logic [3:0]  bomb_cap;
        logic [3:0]  range_cap;
    } cfg_t;

    localparam logic [16:0] RESET_THRESHOLD = 17'd0;  // No spawns yet
    localparam logic [7:0]  RESET_LIFETIME  = 8'd6;
    localparam logic [5:0]  RESET_SPEED_CAP = 6'd28;
    localparam logic [3:0]  RESET_BOMB_CAP  = 4'd9;
    localparam logic [3:0]  RESET_RANGE_CAP = 4'd9;

    // Random source
    localparam logic [15:0] RNG_SEED = 16'hACE1;  // Must be non-zero
    localparam logic [15:0] RNG_TAPS = 16'hB400;  // x^16+x^14+x^13+x^11+1

    // --------------------
    // Player and items
    // --------------------
    typedef struct packed {
        logic [10:0] x;  // Pixel column
        logic [9:0]  y;  // Pixel row
    } player_pos_t;

    typedef struct packed {
        tile_addr_t addr;
        logic       active;
    } slot_state_t;

    typedef struct packed {
        logic [5:0] speed;
        logic [3:0] max_bombs;
        logic [3:0] bomb_range;
    } stats_t;

    localparam logic [5:0] SPEED_INIT = 6'd4;
    localparam logic [5:0] SPEED_STEP = 6'd4;  // Per speed pickup
    localparam logic [3:0] BOMBS_INIT = 4'd1;
    localparam logic [3:0] RANGE_INIT = 4'd1;

endpackage
